// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := scope_tb
RTL_TOP   := scope_top
FLIST     := flist.f
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
scope_pkg.sv
scope_regs.sv
scope_dec_avg.sv
scope_edge.sv
scope_top.sv
tb_clk_gen.sv
scope_tb.sv

// File: scope_dec_avg.sv
`timescale 1ns/1ps
`default_nettype none

module scope_dec_avg (
  input  wire                                 clk,
  input  wire                                 rstn,
  input  wire                                 clr,      // drop partial group
  input  scope_pkg::scope_cfg_t               cfg,
  // input stream
  input  wire  signed [scope_pkg::dwi-1:0]    sti_dat,
  input  wire                                 sti_vld,
  output logic                                sti_rdy,
  // output stream
  output logic signed [scope_pkg::dwo-1:0]    sto_dat,
  output logic                                sto_vld,
  input  wire                                 sto_rdy
);

  logic                                                in_hs;    // input transfer
  logic                        [scope_pkg::dwc-1:0]    dec_eff;  // factor, 0 -> 1
  logic                        [scope_pkg::dwc-1:0]    cnt;      // accepted in group
  logic                                                grp_end;  // d-th sample now
  logic signed [scope_pkg::dwi+scope_pkg::dwc-1:0]     smp_ext;
  logic signed [scope_pkg::dwi+scope_pkg::dwc-1:0]     sum;
  logic signed [scope_pkg::dwi+scope_pkg::dwc-1:0]     sum_nxt;
  logic signed [scope_pkg::dwi+scope_pkg::dwc-1:0]     sum_shr;  // averaged result

  //////////////////////////////
  // handshake
  //////////////////////////////

  // free slot or slot emptied this cycle
  assign sti_rdy = ~sto_vld | sto_rdy;
  assign in_hs   = sti_vld & sti_rdy;

  //////////////////////////////
  // group counter and sum
  //////////////////////////////

  assign dec_eff = (cfg.dec == '0) ? {{(scope_pkg::dwc-1){1'b0}}, 1'b1} : cfg.dec;
  assign grp_end = (cnt >= dec_eff - 1'b1);  // >= covers a factor lowered mid group

  assign smp_ext = sti_dat;            // sign extend
  assign sum_nxt = sum + smp_ext;
  assign sum_shr = sum_nxt >>> cfg.shr;  // arithmetic

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt     <= '0;
      sum     <= '0;
      sto_vld <= 1'b0;
    end else if (clr) begin
      cnt     <= '0;  // discard partial group
      sum     <= '0;
      sto_vld <= 1'b0;
    end else begin
      if (in_hs) begin
        if (grp_end) begin
          cnt <= '0;
          sum <= '0;
        end else begin
          cnt <= cnt + 1'b1;
          sum <= sum_nxt;
        end
      end
      // new result wins over the drain
      if (in_hs && grp_end) begin
        sto_vld <= 1'b1;
      end else if (sto_rdy) begin
        sto_vld <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (in_hs && grp_end) begin
      // low bits only, no saturation
      sto_dat <= cfg.avg ? sum_shr[scope_pkg::dwo-1:0] : smp_ext[scope_pkg::dwo-1:0];
    end
  end

endmodule : scope_dec_avg

`default_nettype wire

// File: scope_edge.sv
`timescale 1ns/1ps
`default_nettype none

module scope_edge (
  input  wire                             clk,
  input  wire                             rstn,
  input  scope_pkg::scope_cfg_t           cfg,
  // observed stream
  input  wire signed [scope_pkg::dwi-1:0] sti_dat,
  input  wire                             sti_vld,
  input  wire                             sti_rdy,
  // triggers
  output logic                            trg_pdg,  // rising
  output logic                            trg_ndg   // falling
);

  logic                           in_hs;
  logic signed [scope_pkg::dwi:0] smp;     // one guard bit
  logic signed [scope_pkg::dwi:0] lvl_x;
  logic signed [scope_pkg::dwi:0] hst_x;
  logic signed [scope_pkg::dwi:0] thr_lo;  // lvl - hst
  logic signed [scope_pkg::dwi:0] thr_hi;  // lvl + hst
  logic                           arm_p;   // seen below thr_lo
  logic                           arm_n;   // seen above thr_hi

  assign in_hs = sti_vld & sti_rdy;

  // widen first so the thresholds cannot wrap
  assign smp    = sti_dat;
  assign lvl_x  = cfg.lvl;
  assign hst_x  = cfg.hst;
  assign thr_lo = lvl_x - hst_x;
  assign thr_hi = lvl_x + hst_x;

  //////////////////////////////
  // schmitt trigger
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      arm_p   <= 1'b0;
      arm_n   <= 1'b0;
      trg_pdg <= 1'b0;
      trg_ndg <= 1'b0;
    end else begin
      trg_pdg <= in_hs & arm_p & (smp >= lvl_x);  // one cycle pulse
      trg_ndg <= in_hs & arm_n & (smp <= lvl_x);
      if (in_hs) begin
        // rising side
        if (arm_p && smp >= lvl_x) begin
          arm_p <= 1'b0;
        end else if (smp < thr_lo) begin
          arm_p <= 1'b1;
        end
        // falling side, mirrored
        if (arm_n && smp <= lvl_x) begin
          arm_n <= 1'b0;
        end else if (smp > thr_hi) begin
          arm_n <= 1'b1;
        end
      end
    end
  end

endmodule : scope_edge

`default_nettype wire

// File: scope_pkg.sv
`default_nettype none

package scope_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int unsigned dwi = 14;  // input sample, signed
  localparam int unsigned dwo = 14;  // output sample, signed
  localparam int unsigned dwc = 17;  // decimation counter
  localparam int unsigned dws = 4;   // shift amount

  // axi4-lite bus
  localparam int unsigned axi_aw = 8;
  localparam int unsigned axi_dw = 32;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  //////////////////////////////
  // register map
  //////////////////////////////

  localparam logic [axi_aw-1:0] reg_ctl = 8'h00;  // bit 0 clear, bit 1 sw trigger
  localparam logic [axi_aw-1:0] reg_avg = 8'h08;  // averaging enable
  localparam logic [axi_aw-1:0] reg_dec = 8'h0C;  // decimation factor
  localparam logic [axi_aw-1:0] reg_shr = 8'h10;  // sum shift right
  localparam logic [axi_aw-1:0] reg_lvl = 8'h14;  // trigger level
  localparam logic [axi_aw-1:0] reg_hst = 8'h18;  // hysteresis

  // configuration seen by the datapath
  typedef struct packed {
    logic                  avg;  // average instead of pick
    logic [dwc-1:0]        dec;  // 0 acts as 1
    logic [dws-1:0]        shr;
    logic signed [dwi-1:0] lvl;
    logic signed [dwi-1:0] hst;
  } scope_cfg_t;

endpackage : scope_pkg

`default_nettype wire

// File: scope_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scope_regs (
  input  wire                                clk,
  input  wire                                rstn,
  // write address
  input  wire        [scope_pkg::axi_aw-1:0] awaddr,
  input  wire                                awvalid,
  output logic                               awready,
  // write data
  input  wire        [scope_pkg::axi_dw-1:0] wdata,
  input  wire      [scope_pkg::axi_dw/8-1:0] wstrb,
  input  wire                                wvalid,
  output logic                               wready,
  // write response
  output logic                         [1:0] bresp,
  output logic                               bvalid,
  input  wire                                bready,
  // read address
  input  wire        [scope_pkg::axi_aw-1:0] araddr,
  input  wire                                arvalid,
  output logic                               arready,
  // read data
  output logic       [scope_pkg::axi_dw-1:0] rdata,
  output logic                         [1:0] rresp,
  output logic                               rvalid,
  input  wire                                rready,
  // to datapath
  output scope_pkg::scope_cfg_t              cfg,
  output logic                               clr,      // decimator clear pulse
  output logic                               trg_swo   // software trigger pulse
);

  logic                         wr_en;   // aw and w transfer
  logic                         rd_en;   // ar transfer
  logic [scope_pkg::axi_dw-1:0] wr_val;  // old value merged with strobed bytes
  logic                         ctl_wr;  // byte 0 of reg_ctl written

  //////////////////////////////
  // decode helpers
  //////////////////////////////

  // current field value as seen on the bus
  function automatic logic [scope_pkg::axi_dw-1:0] reg_val(
    input logic [scope_pkg::axi_aw-1:0] addr,
    input scope_pkg::scope_cfg_t        c
  );
    case (addr)
      scope_pkg::reg_avg: reg_val = {{(scope_pkg::axi_dw-1){1'b0}}, c.avg};
      scope_pkg::reg_dec: reg_val = {{(scope_pkg::axi_dw-scope_pkg::dwc){1'b0}}, c.dec};
      scope_pkg::reg_shr: reg_val = {{(scope_pkg::axi_dw-scope_pkg::dws){1'b0}}, c.shr};
      scope_pkg::reg_lvl: reg_val = {{(scope_pkg::axi_dw-scope_pkg::dwi){c.lvl[scope_pkg::dwi-1]}},
                                     c.lvl};  // sign extended
      scope_pkg::reg_hst: reg_val = {{(scope_pkg::axi_dw-scope_pkg::dwi){c.hst[scope_pkg::dwi-1]}},
                                     c.hst};
      default:            reg_val = '0;  // ctl and holes read 0
    endcase
  endfunction

  function automatic logic reg_hit(input logic [scope_pkg::axi_aw-1:0] addr);
    case (addr)
      scope_pkg::reg_ctl, scope_pkg::reg_avg, scope_pkg::reg_dec,
      scope_pkg::reg_shr, scope_pkg::reg_lvl, scope_pkg::reg_hst: reg_hit = 1'b1;
      default:                                                     reg_hit = 1'b0;
    endcase
  endfunction

  // byte lane merge
  function automatic logic [scope_pkg::axi_dw-1:0] strb_merge(
    input logic [scope_pkg::axi_dw-1:0]   old_val,
    input logic [scope_pkg::axi_dw-1:0]   new_val,
    input logic [scope_pkg::axi_dw/8-1:0] strb
  );
    logic [scope_pkg::axi_dw-1:0] res;
    for (int i = 0; i < scope_pkg::axi_dw/8; i++) begin
      res[8*i +: 8] = strb[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
    end
    return res;
  endfunction

  //////////////////////////////
  // write channel
  //////////////////////////////

  assign wr_en  = awvalid & awready & wvalid & wready;
  assign wr_val = strb_merge(reg_val(awaddr, cfg), wdata, wstrb);
  assign ctl_wr = wr_en & (awaddr == scope_pkg::reg_ctl) & wstrb[0];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      // take aw and w together, one cycle, only with no response pending
      awready <= awvalid & wvalid & ~awready & ~bvalid;
      wready  <= awvalid & wvalid & ~awready & ~bvalid;
      if (wr_en) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;  // response taken
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      bresp <= reg_hit(awaddr) ? scope_pkg::resp_okay : scope_pkg::resp_slverr;
    end
  end

  // config fields, updated on the bvalid edge
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg     <= '0;
      clr     <= 1'b0;
      trg_swo <= 1'b0;
    end else begin
      clr     <= ctl_wr & wdata[0];
      trg_swo <= ctl_wr & wdata[1];
      if (wr_en) begin
        case (awaddr)
          scope_pkg::reg_avg: cfg.avg <= wr_val[0];
          scope_pkg::reg_dec: cfg.dec <= wr_val[scope_pkg::dwc-1:0];
          scope_pkg::reg_shr: cfg.shr <= wr_val[scope_pkg::dws-1:0];
          scope_pkg::reg_lvl: cfg.lvl <= wr_val[scope_pkg::dwi-1:0];
          scope_pkg::reg_hst: cfg.hst <= wr_val[scope_pkg::dwi-1:0];
          default: ;  // ctl is pulses only, holes ignored
        endcase
      end
    end
  end

  //////////////////////////////
  // read channel
  //////////////////////////////

  assign rd_en = arvalid & arready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid & ~arready & ~rvalid;  // one read in flight
      if (rd_en) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= reg_val(araddr, cfg);
      rresp <= reg_hit(araddr) ? scope_pkg::resp_okay : scope_pkg::resp_slverr;
    end
  end

endmodule : scope_regs

`default_nettype wire

// File: scope_tb.sv
`timescale 1ns/1ps
`default_nettype none

module scope_tb;

  localparam int tmo_cyc = 200;  // clocks per wait
  localparam int n_ent   = 8;

  // one stimulus row
  typedef struct {
    bit avg;
    int dec;
    int shr;
    int lvl;
    int hst;
    int n;      // sample count
    int start;  // ramp start
    int step;   // ramp step
    bit rnd;    // lfsr samples instead of ramp
    bit bp;     // random sto_rdy stalls
  } entry_t;

  logic                               clk;
  logic                               rstn;
  logic        [scope_pkg::axi_aw-1:0] awaddr;
  logic                               awvalid;
  logic                               awready;
  logic        [scope_pkg::axi_dw-1:0] wdata;
  logic      [scope_pkg::axi_dw/8-1:0] wstrb;
  logic                               wvalid;
  logic                               wready;
  logic                         [1:0] bresp;
  logic                               bvalid;
  logic                               bready;
  logic        [scope_pkg::axi_aw-1:0] araddr;
  logic                               arvalid;
  logic                               arready;
  logic        [scope_pkg::axi_dw-1:0] rdata;
  logic                         [1:0] rresp;
  logic                               rvalid;
  logic                               rready;
  logic signed    [scope_pkg::dwi-1:0] sti_dat;
  logic                               sti_vld;
  logic                               sti_rdy;
  logic signed    [scope_pkg::dwo-1:0] sto_dat;
  logic                               sto_vld;
  logic                               sto_rdy;
  logic                               trg_swo;
  logic                         [1:0] trg_out;

  entry_t                          tbl [n_ent];
  logic signed [scope_pkg::dwi-1:0] smp [64];     // samples of the current row
  logic signed [scope_pkg::dwo-1:0] exp_q [$];    // expected outputs
  logic                      [15:0] lfsr = 16'd32509;
  int mism_cnt  = 0;
  int other_cnt = 0;

  // reference model state
  int   cur_avg = 0;
  int   cur_d   = 1;  // effective factor
  int   cur_shr = 0;
  int   cur_lvl = 0;
  int   cur_hst = 0;
  int   dec_cnt = 0;
  int   dec_sum = 0;
  bit   arm_rise = 1'b0;
  bit   arm_fall = 1'b0;
  bit   out_full = 1'b0;  // output register holds a result
  logic [1:0] trg_exp = 2'b00;  // due on the next negedge
  int   exp_p = 0;
  int   exp_n = 0;
  int   obs_p = 0;
  int   obs_n = 0;
  int   out_cnt = 0;  // output transfers seen
  int   swo_cnt = 0;

  tb_clk_gen clk_gen_i (
    .clk  (clk),
    .rstn (rstn)
  );

  scope_top scope_top_i (
    .clk     (clk),
    .rstn    (rstn),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .sti_rdy (sti_rdy),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_rdy (sto_rdy),
    .trg_swo (trg_swo),
    .trg_out (trg_out)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int rand_bits(input int nb);
    int v;
    v = 0;
    for (int i = 0; i < nb; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v    = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  task automatic end_run();
    $display("Errors: %0d mismatch, %0d other", mism_cnt, other_cnt);
    if (mism_cnt == 0 && other_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    other_cnt++;
    $display("Timeout: %s did not respond in time", what);
    end_run();
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mism_cnt++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  //////////////////////////////
  // axi4-lite master
  //////////////////////////////

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int t;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    t = 0;
    @(negedge clk);
    while (!(awready && wready)) begin
      t++;
      if (t > tmo_cyc) fail_timeout("AXI write accept");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    t = 0;
    @(negedge clk);
    while (!bvalid) begin
      t++;
      if (t > tmo_cyc) fail_timeout("AXI write response");
      @(negedge clk);
    end
    resp = bresp;
    @(posedge clk);
    #2;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int t;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    t = 0;
    @(negedge clk);
    while (!arready) begin
      t++;
      if (t > tmo_cyc) fail_timeout("AXI read accept");
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    t = 0;
    @(negedge clk);
    while (!rvalid) begin
      t++;
      if (t > tmo_cyc) fail_timeout("AXI read data");
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #2;
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    logic [1:0] rs;
    axi_write(addr, data, strb, rs);
    check("bresp", rs, scope_pkg::resp_okay);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic  [1:0] rs;
    axi_read(addr, rd, rs);
    check("rresp", rs, scope_pkg::resp_okay);
    check("rdata", rd, exp);
  endtask

  //////////////////////////////
  // reference model and monitor
  //////////////////////////////

  always @(negedge clk) begin
    int s;
    int v;
    logic [1:0] t;
    if (rstn) begin
      check("trg_out", trg_out, trg_exp);  // pulse one cycle after transfer
      check("sto_vld", sto_vld, out_full);
      check("sti_rdy", sti_rdy, !out_full || sto_rdy);  // stall only on a waiting output
      obs_p   += trg_out[0];
      obs_n   += trg_out[1];
      swo_cnt += trg_swo;
      if (sto_vld && sto_rdy) begin
        out_cnt++;
      end
      if (sto_rdy) begin
        out_full = 1'b0;  // drained at the next edge
      end
      t = 2'b00;
      if (sti_vld && sti_rdy) begin
        s = sti_dat;
        // rising arms below lvl minus hst and fires at lvl or above
        if (arm_rise && s >= cur_lvl) begin
          t[0]     = 1'b1;
          arm_rise = 1'b0;
        end else if (s < cur_lvl - cur_hst) begin
          arm_rise = 1'b1;
        end
        // falling side mirrors it
        if (arm_fall && s <= cur_lvl) begin
          t[1]     = 1'b1;
          arm_fall = 1'b0;
        end else if (s > cur_lvl + cur_hst) begin
          arm_fall = 1'b1;
        end
        dec_sum += s;
        dec_cnt++;
        if (dec_cnt >= cur_d) begin  // group complete
          v = (cur_avg != 0) ? (dec_sum >>> cur_shr) : s;
          exp_q.push_back(v[scope_pkg::dwo-1:0]);  // low bits kept
          dec_cnt  = 0;
          dec_sum  = 0;
          out_full = 1'b1;
        end
      end
      trg_exp = t;
      exp_p  += t[0];
      exp_n  += t[1];
    end
  end

  //////////////////////////////
  // stream driver and collector
  //////////////////////////////

  task automatic drive_stream(input int n);
    int t;
    for (int i = 0; i < n; i++) begin
      sti_dat = smp[i];
      sti_vld = 1'b1;
      t = 0;
      @(negedge clk);
      while (!sti_rdy) begin  // held until transfer
        t++;
        if (t > tmo_cyc) fail_timeout("input stream ready");
        @(negedge clk);
      end
      @(posedge clk);
      #2;
    end
    sti_vld = 1'b0;
  endtask

  task automatic collect_stream(input int n_out, input bit bp);
    int k;
    int t;
    logic stall;
    logic signed [scope_pkg::dwo-1:0] last;
    k     = 0;
    t     = 0;
    stall = 1'b0;
    last  = '0;
    while (k < n_out) begin
      sto_rdy = bp ? (rand_bits(1) != 0) : 1'b1;
      @(negedge clk);
      if (stall) begin  // output must hold after a stall
        check("sto_vld", sto_vld, 1'b1);
        check("sto_dat", sto_dat, last);
      end
      stall = sto_vld && !sto_rdy;
      last  = sto_dat;
      if (sto_vld && sto_rdy) begin
        if (exp_q.size() == 0) begin
          other_cnt++;
          $display("Output sample appeared with no expected value");
        end else begin
          check("sto_dat", sto_dat, exp_q.pop_front());
        end
        k++;
        t = 0;
      end else begin
        t++;
        if (t > tmo_cyc) fail_timeout("output stream");
      end
      @(posedge clk);
      #2;
    end
    sto_rdy = 1'b1;
  endtask

  //////////////////////////////
  // test steps
  //////////////////////////////

  task automatic pulse_clr();
    write_ok(scope_pkg::reg_ctl, 32'h1, 4'h1);
    dec_cnt  = 0;  // partial group dropped
    dec_sum  = 0;
    out_full = 1'b0;
    exp_q.delete();
  endtask

  task automatic write_cfg(input entry_t en);
    write_ok(scope_pkg::reg_avg, 32'(en.avg), 4'hF);
    write_ok(scope_pkg::reg_dec, en.dec, 4'hF);
    write_ok(scope_pkg::reg_shr, en.shr, 4'hF);
    write_ok(scope_pkg::reg_lvl, en.lvl, 4'hF);
    write_ok(scope_pkg::reg_hst, en.hst, 4'hF);
    cur_avg = en.avg;
    cur_d   = (en.dec == 0) ? 1 : en.dec;
    cur_shr = en.shr;
    cur_lvl = en.lvl;
    cur_hst = en.hst;
  endtask

  task automatic reg_access_test();
    logic [31:0] rd;
    logic  [1:0] rs;
    int swo0;
    write_ok(scope_pkg::reg_dec, 32'h0001_ABCD, 4'hF);
    read_expect(scope_pkg::reg_dec, 32'h0001_ABCD);
    write_ok(scope_pkg::reg_dec, 32'hFFFF_FFFF, 4'b0010);  // byte 1 only
    read_expect(scope_pkg::reg_dec, 32'h0001_FFCD);
    write_ok(scope_pkg::reg_dec, 32'h00FE_0000, 4'b0100);  // bit 16 cleared
    read_expect(scope_pkg::reg_dec, 32'h0000_FFCD);
    write_ok(scope_pkg::reg_shr, 32'hFF, 4'h1);
    read_expect(scope_pkg::reg_shr, 32'hF);
    write_ok(scope_pkg::reg_avg, 32'h3, 4'h1);
    read_expect(scope_pkg::reg_avg, 32'h1);
    write_ok(scope_pkg::reg_lvl, 32'h3000, 4'h3);  // bit 13 set so negative
    read_expect(scope_pkg::reg_lvl, 32'hFFFF_F000);
    write_ok(scope_pkg::reg_hst, 32'h123, 4'h1);   // upper byte masked
    read_expect(scope_pkg::reg_hst, 32'h23);
    // holes
    axi_write(8'h04, 32'hFFFF_FFFF, 4'hF, rs);
    check("bresp hole", rs, scope_pkg::resp_slverr);
    axi_write(8'h1C, 32'hFFFF_FFFF, 4'hF, rs);
    check("bresp hole", rs, scope_pkg::resp_slverr);
    axi_read(8'h04, rd, rs);
    check("rresp hole", rs, scope_pkg::resp_slverr);
    read_expect(scope_pkg::reg_dec, 32'h0000_FFCD);  // untouched
    read_expect(scope_pkg::reg_lvl, 32'hFFFF_F000);
    read_expect(scope_pkg::reg_hst, 32'h23);
    read_expect(scope_pkg::reg_ctl, 32'h0);
    // sw trigger
    swo0 = swo_cnt;
    write_ok(scope_pkg::reg_ctl, 32'h2, 4'h1);
    idle(4);
    check("trg_swo pulses", swo_cnt - swo0, 1);
  endtask

  task automatic run_entry(input entry_t en);
    int n_out;
    write_cfg(en);
    pulse_clr();
    n_out = en.n / cur_d;  // tail group stays partial
    for (int i = 0; i < en.n; i++) begin
      if (en.rnd) begin
        smp[i] = 14'(rand_bits(scope_pkg::dwi));
      end else begin
        smp[i] = 14'(en.start + i * en.step);
      end
    end
    exp_p   = 0;
    exp_n   = 0;
    obs_p   = 0;
    obs_n   = 0;
    out_cnt = 0;
    fork
      drive_stream(en.n);
      collect_stream(n_out, en.bp);
    join
    idle(3);
    check("sto_vld idle", sto_vld, 1'b0);
    check("output count", out_cnt, n_out);
    check("rising trigger count", obs_p, exp_p);
    check("falling trigger count", obs_n, exp_n);
  endtask

  // clear in mid group so the next output covers only new samples
  task automatic clear_test();
    entry_t en;
    en = '{1'b1, 4, 0, 0, 0, 4, 0, 0, 1'b0, 1'b0};
    write_cfg(en);
    pulse_clr();
    smp[0] = 14'sd600;
    smp[1] = -14'sd300;
    drive_stream(2);
    idle(2);
    pulse_clr();
    out_cnt = 0;
    for (int i = 0; i < 4; i++) begin
      smp[i] = 14'(5 + i);
    end
    fork
      drive_stream(4);
      collect_stream(1, 1'b0);
    join
    idle(3);
    check("output count", out_cnt, 1);
  endtask

  //////////////////////////////
  // main
  //////////////////////////////

  initial begin
    int t;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    sti_dat = '0;
    sti_vld = 1'b0;
    sto_rdy = 1'b1;
    //          avg dec shr  lvl   hst   n  start step rnd bp
    tbl[0] = '{1'b0, 1, 0,     0,    4, 12,  -20,   4, 1'b0, 1'b0};
    tbl[1] = '{1'b0, 3, 0,    20,   10, 30,  100,  -7, 1'b0, 1'b0};
    tbl[2] = '{1'b0, 0, 0,   -50,    0, 16, -100,  10, 1'b0, 1'b0};
    tbl[3] = '{1'b1, 4, 2,     0,  100, 32,    0,   0, 1'b1, 1'b0};
    tbl[4] = '{1'b1, 5, 0,  1000,  500, 25,    0,   0, 1'b1, 1'b1};
    tbl[5] = '{1'b1, 8, 3, -2000,    0, 40,    0,   0, 1'b1, 1'b1};
    tbl[6] = '{1'b0, 2, 0,     0,  200, 24,  300, -25, 1'b0, 1'b1};
    tbl[7] = '{1'b0, 3, 0,     0,    0, 27,    0,   0, 1'b1, 1'b1};
    t = 0;
    while (rstn !== 1'b1) begin
      @(posedge clk);
      t++;
      if (t > tmo_cyc) fail_timeout("reset release");
    end
    @(negedge clk);
    check("outputs after reset",
          {awready, wready, bvalid, arready, rvalid, sto_vld, trg_out, trg_swo}, '0);
    @(posedge clk);
    #2;
    reg_access_test();
    for (int e = 0; e < n_ent; e++) begin
      run_entry(tbl[e]);
    end
    clear_test();
    end_run();
  end

  // overall run limit
  initial begin
    repeat (50000) @(posedge clk);
    fail_timeout("overall run");
  end

endmodule : scope_tb

`default_nettype wire

// File: scope_top.sv
`timescale 1ns/1ps
`default_nettype none

module scope_top (
  input  wire                                clk,
  input  wire                                rstn,
  // axi4-lite slave
  input  wire        [scope_pkg::axi_aw-1:0] awaddr,
  input  wire                                awvalid,
  output logic                               awready,
  input  wire        [scope_pkg::axi_dw-1:0] wdata,
  input  wire      [scope_pkg::axi_dw/8-1:0] wstrb,
  input  wire                                wvalid,
  output logic                               wready,
  output logic                         [1:0] bresp,
  output logic                               bvalid,
  input  wire                                bready,
  input  wire        [scope_pkg::axi_aw-1:0] araddr,
  input  wire                                arvalid,
  output logic                               arready,
  output logic       [scope_pkg::axi_dw-1:0] rdata,
  output logic                         [1:0] rresp,
  output logic                               rvalid,
  input  wire                                rready,
  // adc stream in
  input  wire  signed  [scope_pkg::dwi-1:0]  sti_dat,
  input  wire                                sti_vld,
  output logic                               sti_rdy,
  // decimated stream out
  output logic signed  [scope_pkg::dwo-1:0]  sto_dat,
  output logic                               sto_vld,
  input  wire                                sto_rdy,
  // triggers
  output logic                               trg_swo,
  output logic                         [1:0] trg_out   // 0 rising, 1 falling
);

  scope_pkg::scope_cfg_t cfg;  // shared config
  logic                  clr;

  //////////////////////////////
  // input side
  //////////////////////////////

  scope_regs regs_i (
    .clk     (clk),
    .rstn    (rstn),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .cfg     (cfg),
    .clr     (clr),
    .trg_swo (trg_swo)
  );

  //////////////////////////////
  // processing
  //////////////////////////////

  scope_dec_avg dec_i (
    .clk     (clk),
    .rstn    (rstn),
    .clr     (clr),
    .cfg     (cfg),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .sti_rdy (sti_rdy),  // decimator owns input ready
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_rdy (sto_rdy)
  );

  scope_edge edge_i (
    .clk     (clk),
    .rstn    (rstn),
    .cfg     (cfg),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .sti_rdy (sti_rdy),  // observe only
    .trg_pdg (trg_out[0]),
    .trg_ndg (trg_out[1])
  );

endmodule : scope_top

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rstn
);

  localparam int half_ns = 20;  // 40 ns period
  localparam int rst_cyc = 5;

  initial begin
    clk = 1'b0;
    forever #(half_ns) clk = ~clk;
  end

  // sync reset, released just after an edge
  initial begin
    rstn = 1'b0;
    repeat (rst_cyc) @(posedge clk);
    #2;
    rstn = 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire
